//--- src.f
+incdir+src
src/zmem_pkg.sv
src/zbus_sampler.sv
src/win_pager.sv
src/dram_seq.sv
src/zmem_top.sv
tests/dram_model.sv
tests/tb_zmem.sv

//--- Makefile
# Verilator build and run of the zmem testbench

VERILATOR ?= verilator
TOP       ?= tb_zmem
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) src/zmem_params.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the testbench prints the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_zmem.sv
`default_nettype none

`include "zmem_params.svh"

module tb_zmem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ROM_RD = 8;
	localparam int N_RAND   = 48;
	localparam int N_ALIAS  = 6;
	localparam int N_DROP   = 6;
	localparam int N_LANE   = 6;
	localparam int N_ZCYC   = N_ROM_RD + 4 + N_RAND + 2 + 2 * N_ALIAS + 1 + 2 * N_DROP
		+ 1 + 4 * N_LANE;
	localparam int ACC_TMO  = 64;

	logic        fclk;
	logic        arst_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic [7:0]  d_out;
	logic        d_oe;
	logic        wait_n;
	logic [9:0]  ra;
	logic [15:0] rd_out;
	logic        rd_oe;
	logic [15:0] rd_in;
	logic        rwe_n;
	logic        rucas_n;
	logic        rlcas_n;
	logic        rras0_n;
	logic        rras1_n;

	integer      seed;
	int          test_errs;
	int          proto_errs;
	int          oe_errs = 0;
	int          n_pass;
	int          n_fail;
	logic        rd_seen = 1'b0;

	// reference model state
	logic [7:0]  page_m [4];
	logic        rom_m [4];
	logic [7:0]  mem_m [int];

	zmem_top dut_i (.*);

	dram_model mem_i (
		.ra(ra), .dq_w(rd_out), .dq_oe(rd_oe), .we_n(rwe_n), .ucas_n(rucas_n),
		.lcas_n(rlcas_n), .ras0_n(rras0_n), .ras1_n(rras1_n), .dq_r(rd_in)
	);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	initial
	begin
		repeat (200 * N_ZCYC + 20) @(posedge fclk);
		$display("watchdog expired, the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	// d_oe may only follow a memory read seen at the last edge
	always @(posedge fclk)
		rd_seen <= !mreq_n && !rd_n;

	always @(negedge fclk)
	begin
		if (arst_n)
			assert (!d_oe || rd_seen)
			else
			begin
				$display("d_oe is high outside a memory read at %0t", $time);
				oe_errs++;
			end
	end

	////////////////////////////////////////////////////////////
	// mapping model
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] pattern_word(input logic [20:0] w);
		return w[15:0] ^ {w[20:16], w[20:10]} ^ 16'h5AC3;
	endfunction

	function automatic logic [21:0] byte_addr(input logic [15:0] addr);
		logic [1:0] w;
		logic [7:0] page;
		w = addr[15:14];
		if (rom_m[w])
			page = `ZMEM_ROM_BASE_PAGE + {3'b000, page_m[w][4:0]};
		else
			page = page_m[w];
		return {page, addr[13:0]};
	endfunction

	function automatic logic [7:0] expect_byte(input logic [15:0] addr);
		logic [21:0] ba;
		logic [15:0] f;
		ba = byte_addr(addr);
		f  = pattern_word(ba[21:1]);
		if (mem_m.exists(int'(ba)))
			return mem_m[int'(ba)];
		return ba[0] ? f[15:8] : f[7:0];
	endfunction

	////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////

	task automatic z80_cycle(input logic is_io, input logic rnw, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int cnt;
		a    = addr;
		d_in = wdata;
		m1_n = 1'b1;
		if (is_io)
			iorq_n = 1'b0;
		else
			mreq_n = 1'b0;
		if (rnw)
			rd_n = 1'b0;
		else
			wr_n = 1'b0;
		cnt = 0;
		while (wait_n && cnt < ACC_TMO)
		begin
			@(posedge fclk);
			#1;
			cnt++;
		end
		assert (!wait_n)
		else
		begin
			$display("wait_n never fell for the cycle at %04h", addr);
			proto_errs++;
		end
		cnt = 0;
		while (!wait_n && cnt < ACC_TMO)
		begin
			@(posedge fclk);
			#1;
			cnt++;
		end
		assert (wait_n)
		else
		begin
			$display("wait_n stayed low, the cycle at %04h timed out", addr);
			proto_errs++;
		end
		if (!is_io && rnw)
			assert (d_oe)
			else
			begin
				$display("d_oe is low at the end of the read at %04h", addr);
				proto_errs++;
			end
		rdata  = d_out;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		// bus idle time between z80 cycles
		repeat (3) @(posedge fclk);
		#1;
	endtask

	task automatic page_write(input logic [1:0] win, input logic [7:0] val);
		logic [7:0] unused_rd;
		z80_cycle(1'b1, 1'b0, {win, 6'($random(seed)), `ZMEM_PORT_LO}, val, unused_rd);
		page_m[win] = val;
		rom_m[win]  = val[7];
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] val);
		logic [7:0] unused_rd;
		z80_cycle(1'b0, 1'b0, addr, val, unused_rd);
		if (!rom_m[addr[15:14]])
			mem_m[int'(byte_addr(addr))] = val;
	endtask

	task automatic mem_read_check(input string name, input logic [15:0] addr);
		logic [7:0] got;
		logic [7:0] exp;
		exp = expect_byte(addr);
		z80_cycle(1'b0, 1'b1, addr, 8'h00, got);
		assert (got == exp)
		else
		begin
			$display("** Error %s: addr %04h expected %02h, actual %02h", name, addr, exp, got);
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0)
		begin
			n_pass++;
			$display("test %s: pass", name);
		end
		else
		begin
			n_fail++;
			$display("test %s: fail with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [13:0] off;
		logic [7:0]  val;
		logic [7:0]  pg;
		seed       = 42757;
		test_errs  = 0;
		proto_errs = 0;
		n_pass     = 0;
		n_fail     = 0;
		arst_n     = 1'b0;
		mreq_n     = 1'b1;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		a          = 16'h0000;
		d_in       = 8'h00;
		for (int i = 0; i < 4; i++)
		begin
			page_m[i] = 8'h00;
			rom_m[i]  = 1'b1;
		end
		repeat (10) @(posedge fclk);
		#1;
		arst_n = 1'b1;
		repeat (2) @(posedge fclk);
		#1;

		// window 0 comes up as rom page 0
		assert (wait_n && !d_oe && !rd_oe && rwe_n && rucas_n && rlcas_n && rras0_n && rras1_n)
		else
		begin
			$display("outputs are not at their reset values");
			test_errs++;
		end
		for (int i = 0; i < N_ROM_RD; i++)
			mem_read_check("rom_reset", {2'b00, 14'($random(seed))});
		end_test("rom_reset");

		// ram pages on every window, small address pool so reads hit writes
		for (int w = 0; w < 4; w++)
			page_write(2'(w), 8'($random(seed)) & 8'h7F);
		for (int i = 0; i < N_RAND; i++)
		begin
			off = {10'h155, 4'($random(seed))};
			if ($random(seed) & 1)
				mem_read_check("ram_random", {2'($random(seed)), off});
			else
				mem_write({2'($random(seed)), off}, 8'($random(seed)));
		end
		end_test("ram_random");

		pg = 8'($random(seed)) & 8'h7F;
		page_write(2'd1, pg);
		page_write(2'd2, pg);
		for (int i = 0; i < N_ALIAS; i++)
		begin
			off = 14'($random(seed));
			mem_write({2'b01, off}, 8'($random(seed)));
			mem_read_check("alias", {2'b10, off});
		end
		end_test("alias");

		// written byte always differs from the rom contents
		page_write(2'd3, 8'h80 | (8'($random(seed)) & 8'h1F));
		for (int i = 0; i < N_DROP; i++)
		begin
			off = 14'($random(seed));
			val = ~expect_byte({2'b11, off});
			mem_write({2'b11, off}, val);
			mem_read_check("rom_drop", {2'b11, off});
		end
		end_test("rom_drop");

		page_write(2'd0, 8'($random(seed)) & 8'h7F);
		for (int i = 0; i < N_LANE; i++)
		begin
			off = {13'($random(seed)), 1'b0};
			mem_write({2'b00, off}, 8'($random(seed)));
			mem_write({2'b00, off | 14'h0001}, 8'($random(seed)));
			mem_read_check("byte_lanes", {2'b00, off});
			mem_read_check("byte_lanes", {2'b00, off | 14'h0001});
		end
		end_test("byte_lanes");

		test_errs = proto_errs + oe_errs;
		end_test("wait_oe");

		$display("tests: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/dram_model.sv
`default_nettype none

module dram_model (
	input  logic [9:0]  ra,
	input  logic [15:0] dq_w,
	input  logic        dq_oe,
	input  logic        we_n,
	input  logic        ucas_n,
	input  logic        lcas_n,
	input  logic        ras0_n,
	input  logic        ras1_n,
	output logic [15:0] dq_r
);
	timeunit 1ns;
	timeprecision 100ps;

	// sparse word store
	// unwritten words read back as the fill pattern
	logic [15:0] mem [int];
	logic        bank;
	logic [9:0]  row;
	logic [15:0] rdata_q = 16'h0000;

	assign dq_r = rdata_q;

	// every address bit changes the fill word
	function automatic logic [15:0] pattern_word(input logic [20:0] w);
		return w[15:0] ^ {w[20:16], w[20:10]} ^ 16'h5AC3;
	endfunction

	function automatic logic [15:0] read_word(input logic [20:0] w);
		if (mem.exists(int'(w)))
			return mem[int'(w)];
		return pattern_word(w);
	endfunction

	// row and bank latched as ras falls
	always @(negedge ras0_n or negedge ras1_n)
	begin
		bank = !ras1_n;
		row  = ra;
	end

	// column latched as cas falls
	// cas lines act as byte enables, write data only lands while the controller drives it
	always @(negedge ucas_n or negedge lcas_n)
	begin
		logic [20:0] addr;
		logic [15:0] word;
		addr = {bank, row, ra};
		word = read_word(addr);
		if (we_n)
			rdata_q = word;
		else
		begin
			if (!ucas_n && dq_oe)
				word[15:8] = dq_w[15:8];
			if (!lcas_n && dq_oe)
				word[7:0] = dq_w[7:0];
			mem[int'(addr)] = word;
		end
	end

endmodule

`default_nettype wire

//--- src/zmem_top.sv
`default_nettype none

`include "zmem_params.svh"

module zmem_top (
	input  logic                   fclk,
	input  logic                   arst_n,

	// z80
	input  logic                   mreq_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   m1_n,
	input  logic [`ZMEM_ZA_W-1:0]  a,
	input  logic [`ZMEM_ZD_W-1:0]  d_in,
	output logic [`ZMEM_ZD_W-1:0]  d_out,
	output logic                   d_oe,
	output logic                   wait_n,

	// dram
	output logic [`ZMEM_RA_W-1:0]  ra,
	output logic [`ZMEM_DD_W-1:0]  rd_out,
	output logic                   rd_oe,
	input  logic [`ZMEM_DD_W-1:0]  rd_in,
	output logic                   rwe_n,
	output logic                   rucas_n,
	output logic                   rlcas_n,
	output logic                   rras0_n,
	output logic                   rras1_n
);
	import zmem_pkg::*;

	logic                  bus_req;
	logic                  bus_ack;
	logic [`ZMEM_ZD_W-1:0] bus_rdata;
	cpu_req_t              bus_cmd;
	logic                  mem_req;
	logic                  mem_ack;
	logic [`ZMEM_DD_W-1:0] mem_rdata;
	dram_req_t             mem_cmd;

	zbus_sampler zbus_i (
		.fclk(fclk), .arst_n(arst_n),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.a(a), .d_in(d_in), .d_out(d_out), .d_oe(d_oe), .wait_n(wait_n),
		.bus_req(bus_req), .bus_cmd(bus_cmd), .bus_ack(bus_ack), .bus_rdata(bus_rdata)
	);

	win_pager pager_i (
		.fclk(fclk), .arst_n(arst_n),
		.bus_req(bus_req), .bus_cmd(bus_cmd), .bus_ack(bus_ack), .bus_rdata(bus_rdata),
		.mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	dram_seq dram_i (
		.fclk(fclk), .arst_n(arst_n),
		.mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.ra(ra), .rd_out(rd_out), .rd_oe(rd_oe), .rd_in(rd_in), .rwe_n(rwe_n),
		.rucas_n(rucas_n), .rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n)
	);

endmodule

`default_nettype wire

//--- src/dram_seq.sv
`default_nettype none

`include "zmem_params.svh"

module dram_seq (
	input  logic                   fclk,
	input  logic                   arst_n,

	// from the pager
	input  logic                   mem_req,
	input  zmem_pkg::dram_req_t    mem_cmd,
	output logic                   mem_ack,
	output logic [`ZMEM_DD_W-1:0]  mem_rdata,

	// dram pins
	output logic [`ZMEM_RA_W-1:0]  ra,
	output logic [`ZMEM_DD_W-1:0]  rd_out,
	output logic                   rd_oe,
	input  logic [`ZMEM_DD_W-1:0]  rd_in,
	output logic                   rwe_n,
	output logic                   rucas_n,
	output logic                   rlcas_n,
	output logic                   rras0_n,
	output logic                   rras1_n
);
	import zmem_pkg::*;

	typedef enum logic [2:0] {D_IDLE, D_RAS, D_CAS, D_ACK, D_PRE} state_t;

	state_t                 state;
	logic [`ZMEM_CNT_W-1:0] cnt;
	logic [`ZMEM_RA_W-1:0]  row;
	logic [`ZMEM_RA_W-1:0]  col;
	logic                   last;

	assign row  = mem_cmd.waddr[19:10];
	assign col  = mem_cmd.waddr[9:0];
	assign last = (cnt == '0);

	// row is on the pins before ras falls, column one cycle ahead of cas
	assign ra = (state == D_CAS || (state == D_RAS && last)) ? col : row;

	always_ff @(posedge fclk)
	begin
		if (state == D_IDLE && mem_req)
			rd_out <= mem_cmd.wdata;
		if (state == D_CAS && last && mem_cmd.rnw)
			mem_rdata <= rd_in;
	end

	////////////////////////////////////////////////////////////
	// ras/cas sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= D_IDLE;
			cnt     <= '0;
			mem_ack <= 1'b0;
			rd_oe   <= 1'b0;
			rwe_n   <= 1'b1;
			rucas_n <= 1'b1;
			rlcas_n <= 1'b1;
			rras0_n <= 1'b1;
			rras1_n <= 1'b1;
		end
		else
		begin
			case (state)
			D_IDLE:
				if (mem_req && mem_cmd.drop)
				begin
					mem_ack <= 1'b1;
					state   <= D_ACK;
				end
				else if (mem_req)
				begin
					// bit 20 selects the ras bank
					rras0_n <= mem_cmd.waddr[20];
					rras1_n <= !mem_cmd.waddr[20];
					rwe_n   <= mem_cmd.rnw;
					rd_oe   <= !mem_cmd.rnw;
					cnt     <= `ZMEM_CNT_W'(`ZMEM_T_RAS - 1);
					state   <= D_RAS;
				end
			D_RAS:
				if (last)
				begin
					// reads pull both lanes, writes only the chosen one
					rucas_n <= !(mem_cmd.rnw || mem_cmd.bsel[1]);
					rlcas_n <= !(mem_cmd.rnw || mem_cmd.bsel[0]);
					cnt     <= `ZMEM_CNT_W'(`ZMEM_T_CAS - 1);
					state   <= D_CAS;
				end
				else
					cnt <= cnt - 1'b1;
			D_CAS:
				if (last)
				begin
					rucas_n <= 1'b1;
					rlcas_n <= 1'b1;
					rras0_n <= 1'b1;
					rras1_n <= 1'b1;
					rwe_n   <= 1'b1;
					rd_oe   <= 1'b0;
					mem_ack <= 1'b1;
					state   <= D_ACK;
				end
				else
					cnt <= cnt - 1'b1;
			D_ACK:
				if (!mem_req)
				begin
					mem_ack <= 1'b0;
					cnt     <= `ZMEM_CNT_W'(`ZMEM_T_PRE - 1);
					state   <= D_PRE;
				end
			D_PRE:
				if (last)
					state <= D_IDLE;
				else
					cnt <= cnt - 1'b1;
			default:
				state <= D_IDLE;
			endcase
		end
	end

	a_cas_under_ras: assert property (@(posedge fclk) disable iff (!arst_n)
		!(rucas_n && rlcas_n) |-> !(rras0_n && rras1_n));

endmodule

`default_nettype wire

//--- src/win_pager.sv
`default_nettype none

`include "zmem_params.svh"

module win_pager (
	input  logic                   fclk,
	input  logic                   arst_n,

	// from the bus sampler
	input  logic                   bus_req,
	input  zmem_pkg::cpu_req_t     bus_cmd,
	output logic                   bus_ack,
	output logic [`ZMEM_ZD_W-1:0]  bus_rdata,

	// towards the dram sequencer
	output logic                   mem_req,
	output zmem_pkg::dram_req_t    mem_cmd,
	input  logic                   mem_ack,
	input  logic [`ZMEM_DD_W-1:0]  mem_rdata
);
	import zmem_pkg::*;

	typedef enum logic [1:0] {P_IDLE, P_MEM, P_DONE} state_t;

	state_t                  state;
	win_state_t              win [4];
	win_state_t              cur;
	logic [1:0]              win_sel;
	logic [`ZMEM_PAGE_W-1:0] phys_page;
	dram_req_t               xlat;

	// window number is a15..a14 for both kinds of access
	assign win_sel = bus_cmd.addr[15:14];
	assign cur     = win[win_sel];

	assign phys_page = cur.romnram ?
		`ZMEM_ROM_BASE_PAGE + `ZMEM_PAGE_W'(cur.page.rom.page) : cur.page.ram;

	always_comb
	begin
		xlat.waddr = {phys_page, bus_cmd.addr[13:1]};
		xlat.rnw   = bus_cmd.rnw;
		xlat.bsel  = bus_cmd.addr[0] ? 2'b10 : 2'b01;
		xlat.wdata = {bus_cmd.wdata, bus_cmd.wdata};
		xlat.drop  = cur.romnram && !bus_cmd.rnw;
	end

	always_ff @(posedge fclk)
	begin
		if (state == P_IDLE && bus_req && bus_cmd.is_mem)
			mem_cmd <= xlat;
		if (state == P_MEM && mem_ack)
			bus_rdata <= mem_cmd.bsel[1] ? mem_rdata[15:8] : mem_rdata[7:0];
	end

	////////////////////////////////////////////////////////////
	// page registers and request sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= P_IDLE;
			bus_ack <= 1'b0;
			mem_req <= 1'b0;
			// every window starts as rom page 0
			for (int i = 0; i < 4; i++)
			begin
				win[i].page.ram <= '0;
				win[i].romnram  <= 1'b1;
			end
		end
		else
		begin
			case (state)
			P_IDLE:
				if (bus_req && !bus_cmd.is_mem)
				begin
					win[win_sel].page.ram <= bus_cmd.wdata;
					win[win_sel].romnram  <= bus_cmd.wdata[7];
					bus_ack <= 1'b1;
					state   <= P_DONE;
				end
				else if (bus_req && !mem_ack)
				begin
					mem_req <= 1'b1;
					state   <= P_MEM;
				end
			P_MEM:
				if (mem_ack)
				begin
					mem_req <= 1'b0;
					bus_ack <= 1'b1;
					state   <= P_DONE;
				end
			P_DONE:
				if (!bus_req)
				begin
					bus_ack <= 1'b0;
					state   <= P_IDLE;
				end
			default:
				state <= P_IDLE;
			endcase
		end
	end

	a_req_follows_bus: assert property (@(posedge fclk) disable iff (!arst_n)
		$rose(mem_req) |-> bus_req && $past(bus_req));

endmodule

`default_nettype wire

//--- src/zbus_sampler.sv
`default_nettype none

`include "zmem_params.svh"

module zbus_sampler (
	input  logic                   fclk,
	input  logic                   arst_n,

	// z80 bus
	input  logic                   mreq_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   m1_n,
	input  logic [`ZMEM_ZA_W-1:0]  a,
	input  logic [`ZMEM_ZD_W-1:0]  d_in,
	output logic [`ZMEM_ZD_W-1:0]  d_out,
	output logic                   d_oe,
	output logic                   wait_n,

	// towards the pager
	output logic                   bus_req,
	output zmem_pkg::cpu_req_t     bus_cmd,
	input  logic                   bus_ack,
	input  logic [`ZMEM_ZD_W-1:0]  bus_rdata
);
	import zmem_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_HOLD} state_t;

	state_t state;
	logic   mem_start;
	logic   io_start;
	logic   all_high;

	assign mem_start = !mreq_n && (!rd_n || !wr_n);
	// port write only, int ack has m1 low
	assign io_start  = !iorq_n && !wr_n && m1_n && (a[7:0] == `ZMEM_PORT_LO);
	assign all_high  = mreq_n && iorq_n && rd_n && wr_n;

	// command latched once at the start of a z80 cycle
	always_ff @(posedge fclk)
	begin
		if (state == S_IDLE && (mem_start || io_start))
		begin
			bus_cmd.addr   <= a;
			bus_cmd.rnw    <= wr_n;
			bus_cmd.wdata  <= d_in;
			bus_cmd.is_mem <= mem_start;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (state == S_REQ && bus_ack)
			d_out <= bus_rdata;
	end

	////////////////////////////////////////////////////////////
	// cycle catcher and handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= S_IDLE;
			bus_req <= 1'b0;
			wait_n  <= 1'b1;
			d_oe    <= 1'b0;
		end
		else
		begin
			case (state)
			S_IDLE:
				if (mem_start || io_start)
				begin
					state   <= S_REQ;
					bus_req <= 1'b1;
					wait_n  <= 1'b0;
				end
			S_REQ:
				if (bus_ack)
				begin
					state   <= S_HOLD;
					bus_req <= 1'b0;
					wait_n  <= 1'b1;
					d_oe    <= bus_cmd.is_mem && bus_cmd.rnw && !rd_n;
				end
			S_HOLD:
			begin
				if (rd_n)
					d_oe <= 1'b0;
				// strobes must be seen high before the next cycle
				if (all_high && !bus_ack)
					state <= S_IDLE;
			end
			default:
				state <= S_IDLE;
			endcase
		end
	end

	a_cmd_stable: assert property (@(posedge fclk) disable iff (!arst_n)
		bus_req && !bus_ack |=> $stable(bus_cmd));

endmodule

`default_nettype wire

//--- src/zmem_pkg.sv
`default_nettype none

`include "zmem_params.svh"

package zmem_pkg;

	////////////////////////////////////////////////////////////
	// z80 side request
	////////////////////////////////////////////////////////////

	// is_mem clear means a write to the paging port
	typedef struct packed {
		logic [`ZMEM_ZA_W-1:0] addr;
		logic                  rnw;
		logic [`ZMEM_ZD_W-1:0] wdata;
		logic                  is_mem;
	} cpu_req_t;

	// one page byte, read as a ram page or as a rom page
	typedef union packed {
		logic [`ZMEM_PAGE_W-1:0] ram;
		struct packed {
			logic [`ZMEM_PAGE_W-`ZMEM_ROMPG_W-1:0] unused;
			logic [`ZMEM_ROMPG_W-1:0]              page;
		} rom;
	} page_reg_u;

	typedef struct packed {
		page_reg_u page;
		logic      romnram;
	} win_state_t;

	////////////////////////////////////////////////////////////
	// dram side request
	////////////////////////////////////////////////////////////

	// drop marks a rom write, acked with no dram cycle
	typedef struct packed {
		logic [`ZMEM_WA_W-1:0] waddr;
		logic                  rnw;
		logic [1:0]            bsel;
		logic [`ZMEM_DD_W-1:0] wdata;
		logic                  drop;
	} dram_req_t;

endpackage

`default_nettype wire

//--- src/zmem_params.svh
`ifndef ZMEM_PARAMS_SVH
`define ZMEM_PARAMS_SVH

// z80 bus widths
`define ZMEM_ZA_W 16
`define ZMEM_ZD_W 8

// paging port, low address byte
`define ZMEM_PORT_LO 8'hF7

// dram geometry
`define ZMEM_WA_W 21
`define ZMEM_DD_W 16
`define ZMEM_RA_W 10
`define ZMEM_PAGE_W 8
`define ZMEM_ROMPG_W 5

// rom pages occupy the last 32 ram pages
`define ZMEM_ROM_BASE_PAGE 8'hE0

// dram phase lengths in fclk cycles
`define ZMEM_T_RAS 2
`define ZMEM_T_CAS 2
`define ZMEM_T_PRE 1
`define ZMEM_CNT_W 3

`endif
